//--- rvPipeTop.f
+incdir+include
source/rvIsaPkg.sv
source/rvCorePkg.sv
source/frontEnd.sv
source/registerFile.sv
source/executeStage.sv
source/retireStage.sv
source/rvPipeTop.sv
tb/rvPipeTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module rvPipeTb -f rvPipeTop.f -o rvPipeSim \
    && ./obj_dir/rvPipeSim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/rvPipeTb.sv
`include "rvPipe_consts.svh"

module rvPipeTb;
    import rvCorePkg::*;
    import rvIsaPkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 5;
    localparam int INIT_LEN     = 8;
    localparam int BODY_LEN     = 48;
    localparam int PAD_LEN      = 8;
    localparam int PROG_LEN     = INIT_LEN + BODY_LEN + `NUM_REGS + PAD_LEN;
    localparam int MEM_WORDS    = 256;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (PROG_LEN + 20);

    typedef struct packed {
        wordT addr;
        wordT data;
        wordT cycle;
    } storeT;

    logic  clock;
    logic  rstN;
    instrT instr;
    wordT  instrAddr;
    logic  storeValid;
    wordT  storeAddr;
    wordT  storeData;

    instrT       progMem [MEM_WORDS];
    wordT        modelRegs [`NUM_REGS];
    storeT       expQ [$];
    storeT       expStore;
    logic [31:0] lfsrState;
    int          cycleNum;
    int          errorCount;
    int          checkCount;
    string       testName;

    rvPipeTop i_dut (
        .clock        (clock),
        .i_rstN       (rstN),
        .i_instr      (instr),
        .o_instrAddr  (instrAddr),
        .o_storeValid (storeValid),
        .o_storeAddr  (storeAddr),
        .o_storeData  (storeData)
    );

    assign instr = progMem[instrAddr[9:2]];  // Combinational fetch

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        if (!rstN) begin
            cycleNum <= 0;
        end else begin
            cycleNum <= cycleNum + 1;
        end
    end

    ////////////////////////////////////////
    // Random numbers and encoding
    ////////////////////////////////////////

    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic regIdxT randNonZeroReg();
        logic [31:0] v;
        v = 1 + randBits(5) % 31;
        return v[4:0];
    endfunction

    function automatic logic [11:0] randImm();
        logic [31:0] v;
        v = randBits(12);
        return v[11:0];
    endfunction

    function automatic instrT encR(logic [6:0] f7, regIdxT rs2, regIdxT rs1,
                                   logic [2:0] f3, regIdxT rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic instrT encI(logic [11:0] imm, regIdxT rs1, logic [2:0] f3, regIdxT rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic instrT encS(logic [11:0] imm, regIdxT rs2, regIdxT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    // Ops 0..6 are register ops and 7..11 immediate ops
    function automatic instrT makeAlu(int op, regIdxT rd, regIdxT rs1, regIdxT rs2,
                                      logic [11:0] imm);
        case (op)
            0:       return encR(7'h00, rs2, rs1, F3_ADD, rd);
            1:       return encR(7'h20, rs2, rs1, F3_ADD, rd);
            2:       return encR(7'h00, rs2, rs1, F3_AND, rd);
            3:       return encR(7'h00, rs2, rs1, F3_OR, rd);
            4:       return encR(7'h00, rs2, rs1, F3_SLL, rd);
            5:       return encR(7'h00, rs2, rs1, F3_SRL_SRA, rd);
            6:       return encR(7'h20, rs2, rs1, F3_SRL_SRA, rd);
            7:       return encI(imm, rs1, F3_ADD, rd);
            8:       return encI(imm, rs1, F3_AND, rd);
            9:       return encI({7'h00, imm[4:0]}, rs1, F3_SLL, rd);
            10:      return encI({7'h00, imm[4:0]}, rs1, F3_SRL_SRA, rd);
            default: return encI({7'h20, imm[4:0]}, rs1, F3_SRL_SRA, rd);
        endcase
    endfunction

    function automatic instrT unknownInstr();
        logic [31:0] v;
        logic [6:0]  op;
        case (randBits(2))
            0:       op = 7'h03;  // load
            1:       op = 7'h63;  // branch
            2:       op = 7'h6f;  // jal
            default: op = 7'h73;
        endcase
        v = randBits(25);
        return {v[24:0], op};
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic wordT aluRef(logic [2:0] f3, logic alt, wordT a, wordT b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    // Updates modelRegs and returns 1 for a store
    function automatic logic modelStep(input instrT ins, output wordT addr, output wordT data);
        wordT   a;
        wordT   b;
        wordT   immI;
        wordT   immS;
        regIdxT rd;
        a    = modelRegs[ins[19:15]];
        b    = modelRegs[ins[24:20]];
        rd   = ins[11:7];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        addr = '0;
        data = '0;
        case (ins[6:0])
            OP_REG: begin
                if (rd != 0) modelRegs[rd] = aluRef(ins[14:12], ins[30], a, b);
            end
            OP_IMM: begin
                if (rd != 0) modelRegs[rd] = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'b101,
                                                    a, immI);
            end
            OP_STORE: begin
                addr = a + immS;
                data = b;
                return 1'b1;
            end
            default: ;  // Unknown opcode changes nothing
        endcase
        return 1'b0;
    endfunction

    ////////////////////////////////////////
    // Program build
    ////////////////////////////////////////

    task automatic buildProgram(int t);
        int          pc;
        regIdxT      rd;
        regIdxT      rs1;
        regIdxT      rs2;
        regIdxT      hist [3];
        logic [11:0] off;
        logic [31:0] v;
        hist = '{5'd1, 5'd2, 5'd3};
        for (pc = 0; pc < INIT_LEN + BODY_LEN; pc++) begin
            rd  = randNonZeroReg();
            v   = randBits(10);
            rs1 = v[4:0];
            rs2 = v[9:5];
            if (pc < INIT_LEN) begin
                progMem[pc] = encI(randImm(), 5'd0, F3_ADD, rd);
            end else begin
                case (t)
                    0: progMem[pc] = makeAlu(randBits(4) % 4, rd, rs1, rs2, randImm());
                    1: progMem[pc] = makeAlu(4 + randBits(4) % 8, rd, rs1, rs2, randImm());
                    2: begin
                        // Sources from distance 1, 2 or 3
                        rs1 = hist[randBits(2) % 3];
                        rs2 = hist[randBits(2) % 3];
                        progMem[pc] = makeAlu(randBits(4) % 12, rd, rs1, rs2, randImm());
                    end
                    3: begin
                        if (randBits(1) == 1) rd = 5'd0;
                        if (randBits(1) == 1) rs1 = 5'd0;
                        if (randBits(1) == 1) rs2 = 5'd0;
                        progMem[pc] = makeAlu(randBits(4) % 12, rd, rs1, rs2, randImm());
                    end
                    default: begin
                        v = randBits(2);
                        if (v == 0) begin
                            progMem[pc] = unknownInstr();
                        end else if (v == 1 && pc + 1 < INIT_LEN + BODY_LEN) begin
                            v = randBits(20);
                            progMem[pc] = encI({v[9:0], 2'b00}, 5'd0, F3_ADD, rd);
                            pc++;
                            progMem[pc] = encS({v[19:10], 2'b00}, rs2, rd);
                        end else begin
                            progMem[pc] = makeAlu(randBits(4) % 12, rd, rs1, rs2, randImm());
                        end
                    end
                endcase
            end
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = rd;
        end
        off = 12'h400;
        for (int r = 0; r < `NUM_REGS; r++) begin
            progMem[pc] = encS(off, regIdxT'(r), 5'd0);  // Dump every register
            off = off + 12'd4;
            pc++;
        end
    endtask

    task automatic buildExpected();
        wordT  addr;
        wordT  data;
        storeT s;
        for (int r = 0; r < `NUM_REGS; r++) begin
            modelRegs[r] = '0;
        end
        expQ.delete();
        for (int k = 0; k < PROG_LEN; k++) begin
            if (modelStep(progMem[k], addr, data)) begin
                s.addr  = addr;
                s.data  = data;
                s.cycle = wordT'(k + 3);  // Fetch cycle plus three
                expQ.push_back(s);
            end
        end
    endtask

    ////////////////////////////////////////
    // Checker
    ////////////////////////////////////////

    task automatic reportMismatch(string what, wordT expVal, wordT gotVal);
        $display("ERROR %s %s: expected %h, actual %h", testName, what, expVal, gotVal);
        errorCount++;
    endtask

    always @(negedge clock) begin
        if (rstN) begin
            checkCount++;
            assert (instrAddr == wordT'(cycleNum * 4))
                else reportMismatch("fetch address", wordT'(cycleNum * 4), instrAddr);
            if (storeValid) begin
                assert (expQ.size() != 0) else begin
                    $display("ERROR %s: extra store to %h in cycle %0d, none was expected",
                             testName, storeAddr, cycleNum);
                    errorCount++;
                end
                if (expQ.size() != 0) begin
                    expStore = expQ.pop_front();
                    checkCount++;
                    assert (storeAddr == expStore.addr)
                        else reportMismatch("store address", expStore.addr, storeAddr);
                    assert (storeData == expStore.data)
                        else reportMismatch("store data", expStore.data, storeData);
                    assert (wordT'(cycleNum) == expStore.cycle)
                        else reportMismatch("store cycle", expStore.cycle, wordT'(cycleNum));
                end
            end
        end
    end

    function automatic string nameOf(int t);
        case (t)
            0:       return "reg_alu";
            1:       return "imm_shift";
            2:       return "forwarding";
            3:       return "x0_readonly";
            default: return "store_timing";
        endcase
    endfunction

    task automatic runTest(int t);
        int errBefore;
        int chkBefore;
        @(posedge clock);
        rstN <= 1'b0;
        testName  = nameOf(t);
        errBefore = errorCount;
        chkBefore = checkCount;
        buildProgram(t);
        buildExpected();
        repeat (RESET_CYCLES) @(posedge clock);
        rstN <= 1'b1;
        // Last instruction has left EX/MEM by then
        while (cycleNum < PROG_LEN + 4) @(negedge clock);
        assert (expQ.size() == 0) else begin
            $display("ERROR %s: %0d expected stores never appeared", testName, expQ.size());
            errorCount++;
        end
        expQ.delete();
        $display("Test %s done: %0d checks, %0d errors", testName,
                 checkCount - chkBefore, errorCount - errBefore);
    endtask

    initial begin
        rstN       = 1'b0;
        errorCount = 0;
        checkCount = 0;
        lfsrState  = 32'h9e9d_fa66;
        for (int i = 0; i < MEM_WORDS; i++) begin
            progMem[i] = encI(i[11:0], 5'd0, F3_ADD, 5'd0);  // addi x0, x0, index
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- source/rvPipeTop.sv
module rvPipeTop (
    input  logic            clock,
    input  logic            i_rstN,
    input  rvIsaPkg::instrT i_instr,
    output rvCorePkg::wordT o_instrAddr,
    output logic            o_storeValid,
    output rvCorePkg::wordT o_storeAddr,
    output rvCorePkg::wordT o_storeData
);

    // Decode stage
    rvCorePkg::regIdxT idRs1;
    rvCorePkg::regIdxT idRs2;
    rvCorePkg::regIdxT idRd;
    logic              idValid;
    logic              idUseImm;
    logic              idRegWrite;
    logic              idIsStore;
    rvCorePkg::aluOpT  idAluOp;
    rvCorePkg::wordT   idImm;
    rvCorePkg::wordT   rs1Data;
    rvCorePkg::wordT   rs2Data;

    // Execute stage
    logic              exValid;
    logic              exRegWrite;
    logic              exIsStore;
    rvCorePkg::regIdxT exRd;
    rvCorePkg::wordT   exResult;
    rvCorePkg::wordT   exStoreData;

    // Forwarding and writeback
    rvCorePkg::regIdxT exMemRd;
    logic              exMemRegWrite;
    rvCorePkg::wordT   exMemValue;
    rvCorePkg::regIdxT memWbRd;
    logic              memWbRegWrite;
    rvCorePkg::wordT   memWbValue;

    frontEnd uFront (
        .clock      (clock),
        .i_rstN     (i_rstN),
        .i_instr    (i_instr),
        .o_pc       (o_instrAddr),
        .o_rs1      (idRs1),
        .o_rs2      (idRs2),
        .o_rd       (idRd),
        .o_valid    (idValid),
        .o_useImm   (idUseImm),
        .o_regWrite (idRegWrite),
        .o_isStore  (idIsStore),
        .o_aluOp    (idAluOp),
        .o_imm      (idImm)
    );

    registerFile uRegs (
        .clock     (clock),
        .i_rstN    (i_rstN),
        .i_rs1     (idRs1),
        .i_rs2     (idRs2),
        .i_wrIdx   (memWbRd),
        .i_wrEn    (memWbRegWrite),
        .i_wrData  (memWbValue),
        .o_rs1Data (rs1Data),
        .o_rs2Data (rs2Data)
    );

    executeStage uExec (
        .clock           (clock),
        .i_rstN          (i_rstN),
        .i_valid         (idValid),
        .i_aluOp         (idAluOp),
        .i_useImm        (idUseImm),
        .i_regWrite      (idRegWrite),
        .i_isStore       (idIsStore),
        .i_rd            (idRd),
        .i_rs1           (idRs1),
        .i_rs2           (idRs2),
        .i_imm           (idImm),
        .i_rs1Data       (rs1Data),
        .i_rs2Data       (rs2Data),
        .i_exMemRd       (exMemRd),
        .i_exMemRegWrite (exMemRegWrite),
        .i_exMemValue    (exMemValue),
        .i_memWbRd       (memWbRd),
        .i_memWbRegWrite (memWbRegWrite),
        .i_memWbValue    (memWbValue),
        .o_valid         (exValid),
        .o_regWrite      (exRegWrite),
        .o_isStore       (exIsStore),
        .o_rd            (exRd),
        .o_result        (exResult),
        .o_storeData     (exStoreData)
    );

    retireStage uRetire (
        .clock           (clock),
        .i_rstN          (i_rstN),
        .i_valid         (exValid),
        .i_regWrite      (exRegWrite),
        .i_isStore       (exIsStore),
        .i_rd            (exRd),
        .i_result        (exResult),
        .i_storeData     (exStoreData),
        .o_storeValid    (o_storeValid),
        .o_storeAddr     (o_storeAddr),
        .o_storeData     (o_storeData),
        .o_exMemRd       (exMemRd),
        .o_exMemRegWrite (exMemRegWrite),
        .o_exMemValue    (exMemValue),
        .o_memWbRd       (memWbRd),
        .o_memWbRegWrite (memWbRegWrite),
        .o_memWbValue    (memWbValue)
    );

endmodule

//--- source/retireStage.sv
module retireStage (
    input  logic              clock,
    input  logic              i_rstN,
    input  logic              i_valid,
    input  logic              i_regWrite,
    input  logic              i_isStore,
    input  rvCorePkg::regIdxT i_rd,
    input  rvCorePkg::wordT   i_result,
    input  rvCorePkg::wordT   i_storeData,
    output logic              o_storeValid,
    output rvCorePkg::wordT   o_storeAddr,
    output rvCorePkg::wordT   o_storeData,
    output rvCorePkg::regIdxT o_exMemRd,
    output logic              o_exMemRegWrite,
    output rvCorePkg::wordT   o_exMemValue,
    output rvCorePkg::regIdxT o_memWbRd,
    output logic              o_memWbRegWrite,
    output rvCorePkg::wordT   o_memWbValue
);
    import rvCorePkg::*;

    logic   exMemRegWrite;
    logic   exMemIsStore;
    regIdxT exMemRd;
    wordT   exMemResult;
    wordT   exMemStoreData;

    logic   memWbRegWrite;
    regIdxT memWbRd;
    wordT   memWbValue;

    ////////////////////////////////////////
    // EX/MEM and MEM/WB registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge i_rstN) begin
        if (!i_rstN) begin
            exMemRegWrite <= 1'b0;
            exMemIsStore  <= 1'b0;
            memWbRegWrite <= 1'b0;
        end else begin
            exMemRegWrite <= i_valid && i_regWrite;
            exMemIsStore  <= i_valid && i_isStore;
            memWbRegWrite <= exMemRegWrite;
        end
    end

    always_ff @(posedge clock) begin
        exMemRd        <= i_rd;
        exMemResult    <= i_result;
        exMemStoreData <= i_storeData;
        memWbRd        <= exMemRd;
        memWbValue     <= exMemResult;
    end

    // Store leaves straight from EX/MEM, no handshake
    assign o_storeValid = exMemIsStore;
    assign o_storeAddr  = exMemResult;
    assign o_storeData  = exMemStoreData;

    assign o_exMemRd       = exMemRd;
    assign o_exMemRegWrite = exMemRegWrite;
    assign o_exMemValue    = exMemResult;

    assign o_memWbRd       = memWbRd;          // Register file write port
    assign o_memWbRegWrite = memWbRegWrite;
    assign o_memWbValue    = memWbValue;

    storeWordAligned: assert property (
        @(posedge clock) disable iff (!i_rstN)
        o_storeValid |-> o_storeAddr[1:0] == 2'b00
    );

endmodule

//--- source/executeStage.sv
module executeStage (
    input  logic              clock,
    input  logic              i_rstN,
    input  logic              i_valid,
    input  rvCorePkg::aluOpT  i_aluOp,
    input  logic              i_useImm,
    input  logic              i_regWrite,
    input  logic              i_isStore,
    input  rvCorePkg::regIdxT i_rd,
    input  rvCorePkg::regIdxT i_rs1,
    input  rvCorePkg::regIdxT i_rs2,
    input  rvCorePkg::wordT   i_imm,
    input  rvCorePkg::wordT   i_rs1Data,
    input  rvCorePkg::wordT   i_rs2Data,
    input  rvCorePkg::regIdxT i_exMemRd,
    input  logic              i_exMemRegWrite,
    input  rvCorePkg::wordT   i_exMemValue,
    input  rvCorePkg::regIdxT i_memWbRd,
    input  logic              i_memWbRegWrite,
    input  rvCorePkg::wordT   i_memWbValue,
    output logic              o_valid,
    output logic              o_regWrite,
    output logic              o_isStore,
    output rvCorePkg::regIdxT o_rd,
    output rvCorePkg::wordT   o_result,
    output rvCorePkg::wordT   o_storeData
);
    import rvCorePkg::*;

    logic   idExValid;
    logic   idExRegWrite;
    logic   idExIsStore;
    aluOpT  idExAluOp;
    logic   idExUseImm;
    regIdxT idExRd;
    regIdxT idExRs1;
    regIdxT idExRs2;
    wordT   idExImm;
    wordT   idExRs1Data;
    wordT   idExRs2Data;

    fwdSelT selA;
    fwdSelT selB;
    wordT   opA;
    wordT   opB;
    wordT   aluB;
    logic [4:0] shamt;

    ////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge i_rstN) begin
        if (!i_rstN) begin
            idExValid    <= 1'b0;
            idExRegWrite <= 1'b0;
            idExIsStore  <= 1'b0;
        end else begin
            idExValid    <= i_valid;
            idExRegWrite <= i_valid && i_regWrite;
            idExIsStore  <= i_valid && i_isStore;
        end
    end

    always_ff @(posedge clock) begin
        idExAluOp   <= i_aluOp;
        idExUseImm  <= i_useImm;
        idExRd      <= i_rd;
        idExRs1     <= i_rs1;
        idExRs2     <= i_rs2;
        idExImm     <= i_imm;
        idExRs1Data <= i_rs1Data;
        idExRs2Data <= i_rs2Data;
    end

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////

    // Youngest producer wins
    function automatic fwdSelT pickSource(regIdxT rs);
        fwdSelT sel;
        sel = FWD_NONE;
        if (rs != '0) begin
            if (i_exMemRegWrite && i_exMemRd == rs) begin
                sel = FWD_EXMEM;
            end else if (i_memWbRegWrite && i_memWbRd == rs) begin
                sel = FWD_MEMWB;
            end
        end
        return sel;
    endfunction

    function automatic wordT applySource(fwdSelT sel, wordT regData);
        case (sel)
            FWD_EXMEM: return i_exMemValue;
            FWD_MEMWB: return i_memWbValue;
            default:   return regData;
        endcase
    endfunction

    always_comb begin
        selA = pickSource(idExRs1);
        selB = pickSource(idExRs2);
        opA  = applySource(selA, idExRs1Data);
        opB  = applySource(selB, idExRs2Data);
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    assign aluB  = idExUseImm ? idExImm : opB;
    assign shamt = aluB[4:0];

    always_comb begin
        case (idExAluOp)
            ALU_ADD: o_result = opA + aluB;  // Store address too
            ALU_SUB: o_result = opA - aluB;
            ALU_AND: o_result = opA & aluB;
            ALU_OR:  o_result = opA | aluB;
            ALU_SLL: o_result = opA << shamt;
            ALU_SRL: o_result = opA >> shamt;
            ALU_SRA: o_result = wordT'($signed(opA) >>> shamt);
            default: o_result = '0;
        endcase
    end

    assign o_valid     = idExValid;
    assign o_regWrite  = idExRegWrite;
    assign o_isStore   = idExIsStore;
    assign o_rd        = idExRd;
    assign o_storeData = opB;         // Forwarded rs2, never the immediate

endmodule

//--- source/registerFile.sv
`include "rvPipe_consts.svh"

module registerFile (
    input  logic              clock,
    input  logic              i_rstN,
    input  rvCorePkg::regIdxT i_rs1,
    input  rvCorePkg::regIdxT i_rs2,
    input  rvCorePkg::regIdxT i_wrIdx,
    input  logic              i_wrEn,
    input  rvCorePkg::wordT   i_wrData,
    output rvCorePkg::wordT   o_rs1Data,
    output rvCorePkg::wordT   o_rs2Data
);
    import rvCorePkg::*;

    wordT regs [`NUM_REGS];

    // x0 first, then same-cycle write, then the array
    function automatic wordT readPort(regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_wrEn && idx == i_wrIdx) begin
            return i_wrData;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wrEn && i_wrIdx != '0) begin
            regs[i_wrIdx] <= i_wrData;
        end
    end

    always_comb begin
        o_rs1Data = readPort(i_rs1);
        o_rs2Data = readPort(i_rs2);
    end

    x0StaysZero: assert property (
        @(posedge clock) disable iff (!i_rstN)
        regs[0] == '0
    );

endmodule

//--- source/frontEnd.sv
`include "rvPipe_consts.svh"

module frontEnd (
    input  logic              clock,
    input  logic              i_rstN,
    input  rvIsaPkg::instrT   i_instr,
    output rvCorePkg::wordT   o_pc,
    output rvCorePkg::regIdxT o_rs1,
    output rvCorePkg::regIdxT o_rs2,
    output rvCorePkg::regIdxT o_rd,
    output logic              o_valid,
    output logic              o_useImm,
    output logic              o_regWrite,
    output logic              o_isStore,
    output rvCorePkg::aluOpT  o_aluOp,
    output rvCorePkg::wordT   o_imm
);
    import rvCorePkg::*;
    import rvIsaPkg::*;

    wordT    pc;
    instrT   ifIdInstr;
    logic    ifIdValid;
    rFieldsT fields;

    function automatic aluOpT decodeAlu(funct3T f3, logic alt, logic isReg);
        aluOpT op;
        case (f3)
            F3_ADD:     op = (alt && isReg) ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;  // srai keeps bit 30 too
            F3_OR:      op = ALU_OR;
            F3_AND:     op = ALU_AND;
            default:    op = ALU_ADD;
        endcase
        return op;
    endfunction

    ////////////////////////////////////////
    // Fetch and IF/ID
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge i_rstN) begin
        if (!i_rstN) begin
            pc        <= `RESET_PC;
            ifIdValid <= 1'b0;
        end else begin
            pc        <= pc + `PC_STEP;
            ifIdValid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        ifIdInstr <= i_instr;
    end

    assign o_pc = pc;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    assign fields  = rFieldsT'(ifIdInstr);
    assign o_rs1   = fields.rs1;
    assign o_rs2   = fields.rs2;
    assign o_rd    = fields.rd;
    assign o_valid = ifIdValid;

    always_comb begin
        o_useImm   = 1'b0;
        o_regWrite = 1'b0;
        o_isStore  = 1'b0;
        o_aluOp    = ALU_ADD;
        o_imm      = '0;
        case (fields.opcode)
            OP_REG: begin
                o_regWrite = 1'b1;
                o_aluOp    = decodeAlu(fields.funct3, fields.funct7[5], 1'b1);
            end
            OP_IMM: begin
                o_regWrite = 1'b1;
                o_useImm   = 1'b1;
                o_aluOp    = decodeAlu(fields.funct3, fields.funct7[5], 1'b0);
                o_imm      = {{(`XLEN-12){fields.funct7[6]}}, fields.funct7, fields.rs2};
            end
            OP_STORE: begin
                o_isStore = 1'b1;
                o_useImm  = 1'b1;  // Address is rs1 + imm
                o_imm     = {{(`XLEN-12){fields.funct7[6]}}, fields.funct7, fields.rd};
            end
            default: ;             // Unknown opcode retires as a no-op
        endcase
    end

    regWriteStoreExclusive: assert property (
        @(posedge clock) disable iff (!i_rstN)
        o_valid |-> !(o_regWrite && o_isStore)
    );

endmodule

//--- source/rvCorePkg.sv
`include "rvPipe_consts.svh"

package rvCorePkg;

    typedef logic [`XLEN-1:0]      wordT;
    typedef logic [`REG_IDX_W-1:0] regIdxT;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLL = 4'd4,
        ALU_SRL = 4'd5,
        ALU_SRA = 4'd6
    } aluOpT;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_NONE  = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwdSelT;

endpackage

//--- source/rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] instrT;

    // Only the classes this core executes
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011
    } opcodeT;

    typedef enum logic [2:0] {
        F3_ADD     = 3'b000,  // Also sub, by bit 30
        F3_SLL     = 3'b001,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3T;

    // R-type field layout, rd slot holds imm[4:0] for S-type
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3T     funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rFieldsT;

endpackage

//--- include/rvPipe_consts.svh
`ifndef RVPIPE_CONSTS_SVH
`define RVPIPE_CONSTS_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

`define XLEN      32
`define NUM_REGS  32
`define REG_IDX_W 5

////////////////////////////////////////
// Fetch
////////////////////////////////////////

`define RESET_PC  32'h0000_0000
`define PC_STEP   32'd4       // One word per cycle

`endif
